// File: design/mips_pkg.sv
// memories are word addressed, there is no branch delay slot, and unknown encodings decode to bubbles
`default_nettype none

package mips_pkg;

   // basic widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_num_t;
   // word address, the byte offset never leaves the core
   typedef logic [29:0] waddr_t;

   // primary opcodes that the core executes
   typedef enum logic [5:0] {
      op_r_type = 6'h00,
      op_beq    = 6'h04,
      op_bne    = 6'h05,
      op_addi   = 6'h08,
      op_addiu  = 6'h09,
      op_slti   = 6'h0a,
      op_andi   = 6'h0c,
      op_ori    = 6'h0d,
      op_xori   = 6'h0e,
      op_lui    = 6'h0f,
      op_lw     = 6'h23,
      op_sw     = 6'h2b
   } opcode_e;

   // function field of the r-type group
   typedef enum logic [5:0] {
      fn_sll  = 6'h00,
      fn_srl  = 6'h02,
      fn_sra  = 6'h03,
      fn_add  = 6'h20,
      fn_addu = 6'h21,
      fn_sub  = 6'h22,
      fn_subu = 6'h23,
      fn_and  = 6'h24,
      fn_or   = 6'h25,
      fn_xor  = 6'h26,
      fn_nor  = 6'h27,
      fn_slt  = 6'h2a,
      fn_sltu = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
   } alu_op_e;

   // operand source in execute
   typedef enum logic [1:0] {
      from_reg, from_mem, from_wb
   } fwd_sel_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    branch;
      // bne when set, beq otherwise
      logic    branch_ne;
   } ctrl_t;

   // no enables set, so nothing is written and nothing redirects
   localparam ctrl_t ctrl_bubble = '{
      alu_op: alu_add, use_imm: 1'b0, reg_write: 1'b0, mem_read: 1'b0,
      mem_write: 1'b0, branch: 1'b0, branch_ne: 1'b0
   };

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc_plus4;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      logic [4:0] shamt;
      reg_num_t rs_num;
      reg_num_t rt_num;
      reg_num_t wr_num;
   } id_ex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_result;
      word_t    store_val;
      reg_num_t wr_num;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_write;
      reg_num_t wr_num;
      word_t    wb_val;
   } mem_wb_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire

// File: design/fetch_unit.sv
// pc is assumed word aligned; text_start must be a multiple of four
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
   import mips_pkg::*;
#(
   parameter word_t text_start = 32'h00400000
) (
   input  logic      clk,
   input  logic      rst_b,
   input  logic      stall,
   input  logic      flush,
   input  redirect_t redirect,
   output waddr_t    inst_addr,
   input  word_t     inst,
   output word_t     if_inst,
   output word_t     if_pc_plus4
);

   word_t pc;
   word_t pc_plus4;

   assign pc_plus4  = pc + 32'd4;
   // memory takes word addresses
   assign inst_addr = pc[31:2];

   // pc and the if/id instruction
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc      <= text_start;
         if_inst <= '0;
      end else if (flush) begin
         // branch target wins, the fetched word is dropped
         pc      <= redirect.target;
         // all-zero word is sll $0 and writes nothing
         if_inst <= '0;
      end else if (!stall) begin
         pc      <= pc_plus4;
         if_inst <= inst;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall)
         if_pc_plus4 <= pc_plus4;
   end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
// decodes only the kept integer subset; anything else leaves as a bubble with no enables
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
   import mips_pkg::*;
(
   input  word_t    if_inst,
   input  word_t    if_pc_plus4,
   output reg_num_t rs_num,
   output reg_num_t rt_num,
   input  word_t    rs_val,
   input  word_t    rt_val,
   output id_ex_t   id
);

   opcode_e  op;
   funct_e   fn;
   reg_num_t rd_num;
   reg_num_t wr_num;
   logic     zero_ext;
   ctrl_t    ctrl;

   // field split
   assign op     = opcode_e'(if_inst[31:26]);
   assign fn     = funct_e'(if_inst[5:0]);
   assign rs_num = if_inst[25:21];
   assign rt_num = if_inst[20:16];
   assign rd_num = if_inst[15:11];

   // logical immediates are zero extended
   assign zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);

   always_comb begin
      ctrl   = ctrl_bubble;
      wr_num = rt_num;
      case (op)
         op_r_type: begin
            wr_num         = rd_num;
            ctrl.reg_write = 1'b1;
            case (fn)
               // no overflow traps, so signed and unsigned adds match
               fn_add, fn_addu: ctrl.alu_op = alu_add;
               fn_sub, fn_subu: ctrl.alu_op = alu_sub;
               fn_and:          ctrl.alu_op = alu_and;
               fn_or:           ctrl.alu_op = alu_or;
               fn_xor:          ctrl.alu_op = alu_xor;
               fn_nor:          ctrl.alu_op = alu_nor;
               fn_slt:          ctrl.alu_op = alu_slt;
               fn_sltu:         ctrl.alu_op = alu_sltu;
               fn_sll:          ctrl.alu_op = alu_sll;
               fn_srl:          ctrl.alu_op = alu_srl;
               fn_sra:          ctrl.alu_op = alu_sra;
               default:         ctrl = ctrl_bubble;
            endcase
         end
         op_addi, op_addiu: begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         op_slti: begin
            ctrl.alu_op    = alu_slt;
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         op_andi, op_ori, op_xori: begin
            ctrl.alu_op    = (op == op_andi) ? alu_and : (op == op_ori) ? alu_or : alu_xor;
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         op_lui: begin
            ctrl.alu_op    = alu_lui;
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         op_lw: begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
         end
         op_sw: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         op_beq, op_bne: begin
            // compare is done apart from the alu
            ctrl.branch    = 1'b1;
            ctrl.branch_ne = (op == op_bne);
         end
         default: ctrl = ctrl_bubble;
      endcase
      // writes to $0 are dropped here so no later stage sees them
      if (wr_num == '0)
         ctrl.reg_write = 1'b0;
   end

   always_comb begin
      id.ctrl     = ctrl;
      id.pc_plus4 = if_pc_plus4;
      id.rs_val   = rs_val;
      id.rt_val   = rt_val;
      id.imm      = zero_ext ? {16'h0, if_inst[15:0]} : {{16{if_inst[15]}}, if_inst[15:0]};
      id.shamt    = if_inst[10:6];
      id.rs_num   = rs_num;
      id.rt_num   = rt_num;
      // non-writers carry $0 so hazard compares stay quiet
      id.wr_num   = ctrl.reg_write ? wr_num : '0;
   end

endmodule

`default_nettype wire

// File: design/register_file.sv
// register contents are undefined after reset except $0, which always reads zero
`timescale 1ns/1ps
`default_nettype none

module register_file
   import mips_pkg::*;
(
   input  logic     clk,
   input  logic     rst_b,
   input  reg_num_t rs_num,
   input  reg_num_t rt_num,
   output word_t    rs_val,
   output word_t    rt_val,
   input  mem_wb_t  wb
);

   word_t regs [32];

   // $0 reads zero, a same-cycle write passes straight through
   function automatic word_t read_port(reg_num_t num);
      word_t val;
      if (num == '0)
         val = '0;
      else if (wb.reg_write && (wb.wr_num == num))
         val = wb.wb_val;
      else
         val = regs[num];
      return val;
   endfunction

   always_comb begin
      rs_val = read_port(rs_num);
      rt_val = read_port(rt_num);
   end

   // write at the end of writeback
   always_ff @(posedge clk) begin
      if (wb.reg_write && (wb.wr_num != '0))
         regs[wb.wr_num] <= wb.wb_val;
   end

   // mem/wb control must be clean once reset is released
   wb_enable_known: assert property (
      @(posedge clk) disable iff (!rst_b) !$isunknown(wb.reg_write)
   );

endmodule

`default_nettype wire

// File: design/execute_unit.sv
// one-cycle execute; branches resolve here and cost two cycles when taken
`timescale 1ns/1ps
`default_nettype none

module execute_unit
   import mips_pkg::*;
(
   input  logic      clk,
   input  logic      rst_b,
   input  id_ex_t    id,
   input  logic      bubble,
   input  fwd_sel_e  fwd_a,
   input  fwd_sel_e  fwd_b,
   input  mem_wb_t   wb,
   output ctrl_t     ex_ctrl,
   output reg_num_t  ex_rs_num,
   output reg_num_t  ex_rt_num,
   output reg_num_t  ex_wr_num,
   output redirect_t redirect,
   output ex_mem_t   ex_mem
);

   id_ex_t id_q;
   word_t  op_a;
   word_t  op_b;
   word_t  alu_b;
   word_t  alu_result;
   logic   equal;

   // id/ex register
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         id_q <= '{ctrl: ctrl_bubble, default: '0};
      else if (bubble)
         id_q <= '{ctrl: ctrl_bubble, default: '0};
      else
         id_q <= id;
   end

   assign ex_ctrl   = id_q.ctrl;
   assign ex_rs_num = id_q.rs_num;
   assign ex_rt_num = id_q.rt_num;
   assign ex_wr_num = id_q.wr_num;

   // operand source picked by the hazard unit
   function automatic word_t fwd_pick(fwd_sel_e sel, word_t reg_val);
      word_t val;
      case (sel)
         from_mem: val = ex_mem.alu_result;
         from_wb:  val = wb.wb_val;
         default:  val = reg_val;
      endcase
      return val;
   endfunction

   always_comb begin
      op_a = fwd_pick(fwd_a, id_q.rs_val);
      op_b = fwd_pick(fwd_b, id_q.rt_val);
   end

   assign alu_b = id_q.ctrl.use_imm ? id_q.imm : op_b;

   // shifts act on rt by the shamt field
   always_comb begin
      case (id_q.ctrl.alu_op)
         alu_add:  alu_result = op_a + alu_b;
         alu_sub:  alu_result = op_a - alu_b;
         alu_and:  alu_result = op_a & alu_b;
         alu_or:   alu_result = op_a | alu_b;
         alu_xor:  alu_result = op_a ^ alu_b;
         alu_nor:  alu_result = ~(op_a | alu_b);
         alu_slt:  alu_result = {31'h0, $signed(op_a) < $signed(alu_b)};
         alu_sltu: alu_result = {31'h0, op_a < alu_b};
         alu_sll:  alu_result = alu_b << id_q.shamt;
         alu_srl:  alu_result = alu_b >> id_q.shamt;
         alu_sra:  alu_result = word_t'($signed(alu_b) >>> id_q.shamt);
         alu_lui:  alu_result = {id_q.imm[15:0], 16'h0};
         default:  alu_result = op_a + alu_b;
      endcase
   end

   // beq and bne compare the forwarded registers
   assign equal = (op_a == op_b);

   always_comb begin
      redirect.taken  = id_q.ctrl.branch && (id_q.ctrl.branch_ne ? !equal : equal);
      // target is relative to the next sequential pc
      redirect.target = id_q.pc_plus4 + {id_q.imm[29:0], 2'b00};
   end

   // ex/mem register
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '{ctrl: ctrl_bubble, default: '0};
      end else begin
         ex_mem.ctrl       <= id_q.ctrl;
         ex_mem.alu_result <= alu_result;
         // store data must see forwarded rt
         ex_mem.store_val  <= op_b;
         ex_mem.wr_num     <= id_q.wr_num;
      end
   end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
// whole-word accesses only; the low two address bits are dropped and never checked
`timescale 1ns/1ps
`default_nettype none

module memory_stage
   import mips_pkg::*;
(
   input  logic    clk,
   input  logic    rst_b,
   input  ex_mem_t ex_mem,
   output waddr_t  mem_addr,
   output word_t   mem_wdata,
   output logic    mem_we,
   input  word_t   mem_rdata,
   output mem_wb_t wb
);

   word_t wb_val;

   // data port driven straight from ex/mem
   assign mem_addr  = ex_mem.alu_result[31:2];
   assign mem_wdata = ex_mem.store_val;
   // one-cycle strobe while the store sits in mem
   assign mem_we    = ex_mem.ctrl.mem_write;

   // loads take the memory word, everything else the alu result
   assign wb_val = ex_mem.ctrl.mem_read ? mem_rdata : ex_mem.alu_result;

   // mem/wb register
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb <= '0;
      end else begin
         wb.reg_write <= ex_mem.ctrl.reg_write;
         wb.wr_num    <= ex_mem.wr_num;
         wb.wb_val    <= wb_val;
      end
   end

   // decode never builds an access that both reads and writes
   no_read_and_write: assert property (
      @(posedge clk) disable iff (!rst_b) !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write)
   );

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// assumes loads are the only producers that need a stall; forwarding covers every other case
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
   import mips_pkg::*;
(
   input  logic     clk,
   input  logic     rst_b,
   input  reg_num_t id_rs_num,
   input  reg_num_t id_rt_num,
   input  reg_num_t ex_rs_num,
   input  reg_num_t ex_rt_num,
   input  reg_num_t ex_wr_num,
   input  logic     ex_mem_read,
   input  reg_num_t mem_wr_num,
   input  logic     mem_reg_write,
   input  reg_num_t wb_wr_num,
   input  logic     wb_reg_write,
   input  logic     redirect_taken,
   output logic     stall,
   output logic     flush,
   output fwd_sel_e fwd_a,
   output fwd_sel_e fwd_b
);

   // youngest producer wins, so mem overrides wb
   function automatic fwd_sel_e pick(reg_num_t src);
      fwd_sel_e sel;
      sel = from_reg;
      if ((src != '0) && wb_reg_write && (wb_wr_num == src))
         sel = from_wb;
      if ((src != '0) && mem_reg_write && (mem_wr_num == src))
         sel = from_mem;
      return sel;
   endfunction

   always_comb begin
      fwd_a = pick(ex_rs_num);
      fwd_b = pick(ex_rt_num);
   end

   // load in ex feeding the instruction in id
   // data is only ready from wb, so hold one cycle
   assign stall = ex_mem_read && (ex_wr_num != '0) &&
                  ((ex_wr_num == id_rs_num) || (ex_wr_num == id_rt_num));

   // taken branch drops the ids and ifs instructions
   assign flush = redirect_taken;

   // a load and a branch never share the ex slot
   no_stall_with_flush: assert property (
      @(posedge clk) disable iff (!rst_b) !(stall && flush)
   );

endmodule

`default_nettype wire

// File: design/mips_core.sv
// instruction and data memories sit outside with same-cycle reads; stores are a one-cycle strobe
`timescale 1ns/1ps
`default_nettype none

module mips_core
   import mips_pkg::*;
#(
   parameter word_t text_start = 32'h00400000
) (
   input  logic   clk,
   input  logic   rst_b,
   output waddr_t inst_addr,
   input  word_t  inst,
   output waddr_t mem_addr,
   output word_t  mem_wdata,
   input  word_t  mem_rdata,
   output logic   mem_we
);

   // if/id outputs
   word_t     if_inst;
   word_t     if_pc_plus4;
   // decode and register file
   reg_num_t  rs_num;
   reg_num_t  rt_num;
   word_t     rs_val;
   word_t     rt_val;
   id_ex_t    id;
   // execute stage view for the hazard unit
   ctrl_t     ex_ctrl;
   reg_num_t  ex_rs_num;
   reg_num_t  ex_rt_num;
   reg_num_t  ex_wr_num;
   redirect_t redirect;
   ex_mem_t   ex_mem;
   mem_wb_t   wb;
   // hazard controls
   logic      stall;
   logic      flush;
   fwd_sel_e  fwd_a;
   fwd_sel_e  fwd_b;

   fetch_unit #(.text_start(text_start)) fetch_unit_inst (
      .clk(clk), .rst_b(rst_b), .stall(stall), .flush(flush), .redirect(redirect),
      .inst_addr(inst_addr), .inst(inst), .if_inst(if_inst), .if_pc_plus4(if_pc_plus4)
   );

   instr_decoder instr_decoder_inst (
      .if_inst(if_inst), .if_pc_plus4(if_pc_plus4), .rs_num(rs_num), .rt_num(rt_num),
      .rs_val(rs_val), .rt_val(rt_val), .id(id)
   );

   register_file register_file_inst (
      .clk(clk), .rst_b(rst_b), .rs_num(rs_num), .rt_num(rt_num),
      .rs_val(rs_val), .rt_val(rt_val), .wb(wb)
   );

   // a stall or a flush both put a bubble into execute
   execute_unit execute_unit_inst (
      .clk(clk), .rst_b(rst_b), .id(id), .bubble(stall | flush),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .wb(wb), .ex_ctrl(ex_ctrl),
      .ex_rs_num(ex_rs_num), .ex_rt_num(ex_rt_num), .ex_wr_num(ex_wr_num),
      .redirect(redirect), .ex_mem(ex_mem)
   );

   memory_stage memory_stage_inst (
      .clk(clk), .rst_b(rst_b), .ex_mem(ex_mem), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata), .wb(wb)
   );

   hazard_unit hazard_unit_inst (
      .clk(clk), .rst_b(rst_b),
      .id_rs_num(rs_num), .id_rt_num(rt_num),
      .ex_rs_num(ex_rs_num), .ex_rt_num(ex_rt_num), .ex_wr_num(ex_wr_num),
      .ex_mem_read(ex_ctrl.mem_read),
      .mem_wr_num(ex_mem.wr_num), .mem_reg_write(ex_mem.ctrl.reg_write),
      .wb_wr_num(wb.wr_num), .wb_reg_write(wb.reg_write),
      .redirect_taken(redirect.taken),
      .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

endmodule

`default_nettype wire

// File: testbench/tb_memory.sv
// 256 words each; upper address bits are ignored, so addresses alias every 1 KB
`timescale 1ns/1ps
`default_nettype none

module tb_memory
   import mips_pkg::*;
(
   input  logic   clk,
   input  waddr_t inst_addr,
   output word_t  inst,
   input  waddr_t mem_addr,
   input  word_t  mem_wdata,
   input  logic   mem_we,
   output word_t  mem_rdata
);

   // contents are loaded by the testbench before reset ends
   word_t rom [256];
   word_t ram [256];

   // both reads answer in the same cycle
   assign inst      = rom[inst_addr[7:0]];
   assign mem_rdata = ram[mem_addr[7:0]];

   // store strobe writes on this edge
   always @(posedge clk) begin
      if (mem_we)
         ram[mem_addr[7:0]] <= mem_wdata;
   end

endmodule

`default_nettype wire

// File: testbench/tb_mips_core.sv
// program and data must fit in 256-word memories; store order assumes no branch delay slot
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
   import mips_pkg::*;
();

   localparam word_t text_start    = 32'h00400000;
   localparam int    store_timeout = 100;
   localparam int    tail_cycles   = 30;

   logic   clk;
   logic   rst_b;
   waddr_t inst_addr;
   word_t  inst;
   waddr_t mem_addr;
   word_t  mem_wdata;
   word_t  mem_rdata;
   logic   mem_we;

   word_t       program_words [$];
   word_t       data_words [256];
   // expected stores in program order
   string       exp_name [$];
   waddr_t      exp_addr [$];
   word_t       exp_data [$];
   logic [15:0] lfsr_state;
   int          error_count;
   int          check_count;
   logic        timed_out;

   mips_core #(.text_start(text_start)) mips_core_inst (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_we(mem_we)
   );

   tb_memory tb_memory_inst (
      .clk(clk), .inst_addr(inst_addr), .inst(inst), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hb400;
      return n;
   endfunction

   // one lfsr step per bit
   task automatic random_word(output word_t w);
      w = '0;
      for (int b = 0; b < 32; b++) begin
         w = {w[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic word_t r_inst(logic [5:0] funct, reg_num_t rs, reg_num_t rt,
                                    reg_num_t rd, logic [4:0] shamt);
      return {6'h00, rs, rt, rd, shamt, funct};
   endfunction

   function automatic word_t i_inst(logic [5:0] op, reg_num_t rs, reg_num_t rt,
                                    logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic add_store(string name, waddr_t addr, word_t data);
      exp_name.push_back(name);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic build_program();
      // alu chain, each result feeds the next from mem or wb
      program_words.push_back(i_inst(op_addi, 5'd0, 5'd1, 16'h1234));
      program_words.push_back(i_inst(op_addi, 5'd1, 5'd2, 16'hfffc));
      program_words.push_back(r_inst(fn_sub, 5'd2, 5'd1, 5'd3, 5'd0));
      program_words.push_back(i_inst(op_lui, 5'd0, 5'd4, 16'ha5a5));
      program_words.push_back(i_inst(op_ori, 5'd4, 5'd4, 16'h00f0));
      program_words.push_back(r_inst(fn_sra, 5'd0, 5'd4, 5'd5, 5'd4));
      program_words.push_back(r_inst(fn_srl, 5'd0, 5'd4, 5'd6, 5'd8));
      program_words.push_back(r_inst(fn_sll, 5'd0, 5'd1, 5'd7, 5'd3));
      program_words.push_back(r_inst(fn_nor, 5'd3, 5'd0, 5'd8, 5'd0));
      program_words.push_back(r_inst(fn_xor, 5'd7, 5'd8, 5'd9, 5'd0));
      // first store takes its data straight from mem
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd9, 16'h0110));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd2, 16'h0100));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd3, 16'h0104));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd5, 16'h0108));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd6, 16'h010c));
      // load then an immediate reader of it
      program_words.push_back(i_inst(op_lw, 5'd0, 5'd10, 16'h0000));
      program_words.push_back(i_inst(op_lw, 5'd0, 5'd11, 16'h0004));
      program_words.push_back(r_inst(fn_add, 5'd10, 5'd11, 5'd12, 5'd0));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd12, 16'h0114));
      // taken beq over two stores
      program_words.push_back(i_inst(op_beq, 5'd1, 5'd1, 16'h0002));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd1, 16'h0118));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd2, 16'h011c));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd7, 16'h0120));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd4, 16'h0124));
      // bne on equal forwarded values falls through
      program_words.push_back(i_inst(op_addi, 5'd0, 5'd13, 16'h0005));
      program_words.push_back(i_inst(op_addi, 5'd0, 5'd14, 16'h0005));
      program_words.push_back(i_inst(op_bne, 5'd13, 5'd14, 16'h0002));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd13, 16'h0128));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd14, 16'h012c));
      // signed and unsigned compares, $15 gets its top bit forced
      program_words.push_back(i_inst(op_lw, 5'd0, 5'd15, 16'h0008));
      program_words.push_back(i_inst(op_lw, 5'd0, 5'd16, 16'h000c));
      program_words.push_back(i_inst(op_lui, 5'd0, 5'd17, 16'h8000));
      program_words.push_back(r_inst(fn_or, 5'd15, 5'd17, 5'd15, 5'd0));
      program_words.push_back(r_inst(fn_slt, 5'd15, 5'd16, 5'd18, 5'd0));
      program_words.push_back(r_inst(fn_sltu, 5'd15, 5'd16, 5'd19, 5'd0));
      program_words.push_back(r_inst(fn_sltu, 5'd16, 5'd15, 5'd20, 5'd0));
      program_words.push_back(i_inst(op_slti, 5'd15, 5'd21, 16'h0000));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd18, 16'h0130));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd19, 16'h0134));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd20, 16'h0138));
      program_words.push_back(i_inst(op_sw, 5'd0, 5'd21, 16'h013c));
   endtask

   // values worked out by hand from the isa, data words from the lfsr
   task automatic build_expected();
      word_t x;
      word_t y;
      logic  signed_lt;
      x = data_words[2] | 32'h80000000;
      y = data_words[3];
      // differing signs decide by the sign bit, equal signs by magnitude
      signed_lt = (x[31] != y[31]) ? x[31] : (x < y);
      add_store("alu_fwd", 30'h44, 32'h000091a3);
      add_store("alu_fwd", 30'h40, 32'h00001230);
      add_store("alu_fwd", 30'h41, 32'hfffffffc);
      add_store("alu_fwd", 30'h42, 32'hfa5a500f);
      add_store("alu_fwd", 30'h43, 32'h00a5a500);
      add_store("load_use", 30'h45, data_words[0] + data_words[1]);
      // words 0x46 and 0x47 never get written
      add_store("beq_taken", 30'h48, 32'h000091a0);
      add_store("beq_taken", 30'h49, 32'ha5a500f0);
      add_store("bne_fall", 30'h4a, 32'h00000005);
      add_store("bne_fall", 30'h4b, 32'h00000005);
      add_store("slt_signs", 30'h4c, {31'h0, signed_lt});
      add_store("slt_signs", 30'h4d, {31'h0, x < y});
      add_store("slt_signs", 30'h4e, {31'h0, y < x});
      add_store("slt_signs", 30'h4f, 32'h00000001);
   endtask

   // sample at the falling edge, well clear of the rising edge updates
   task automatic wait_for_store(output logic seen, output waddr_t addr, output word_t data);
      int cycles;
      seen   = 1'b0;
      addr   = '0;
      data   = '0;
      cycles = 0;
      while (!seen && (cycles < store_timeout)) begin
         @(negedge clk);
         cycles++;
         if (mem_we) begin
            seen = 1'b1;
            addr = mem_addr;
            data = mem_wdata;
         end
      end
   endtask

   task automatic check_word(string name, string field, word_t expected, word_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Fail %s %s: expected %h, actual %h", name, field, expected, actual);
      end
   endtask

   initial begin
      logic   seen;
      waddr_t got_addr;
      word_t  got_data;
      error_count = 0;
      check_count = 0;
      timed_out   = 1'b0;
      rst_b       = 1'b0;
      lfsr_state  = 16'd27282;
      for (int i = 0; i < 256; i++)
         random_word(data_words[i]);
      build_program();
      build_expected();
      // unused rom words stay zero, which runs as nop
      for (int i = 0; i < 256; i++) begin
         tb_memory_inst.rom[i] <= (i < program_words.size()) ? program_words[i] : '0;
         tb_memory_inst.ram[i] <= data_words[i];
      end

      // no store may leave the core while in reset
      repeat (16) begin
         @(negedge clk);
         if (mem_we !== 1'b0) begin
            error_count++;
            $display("store strobe seen while reset was held");
         end
      end
      @(posedge clk);
      rst_b <= 1'b1;
      @(negedge clk);
      check_word("reset", "inst_addr", {2'b00, text_start[31:2]}, {2'b00, inst_addr});
      if (mem_we !== 1'b0) begin
         error_count++;
         $display("store strobe seen in the first cycle after reset");
      end

      for (int i = 0; i < exp_addr.size(); i++) begin
         if (!timed_out) begin
            wait_for_store(seen, got_addr, got_data);
            if (!seen) begin
               timed_out = 1'b1;
               error_count++;
               $display("no store for %s within %0d cycles", exp_name[i], store_timeout);
            end else begin
               check_word(exp_name[i], "address", {2'b00, exp_addr[i]}, {2'b00, got_addr});
               check_word(exp_name[i], "data", exp_data[i], got_data);
            end
         end
      end

      // skipped or repeated stores would show up here
      if (!timed_out) begin
         repeat (tail_cycles) begin
            @(negedge clk);
            if (mem_we) begin
               error_count++;
               $display("unexpected store to word %h with data %h", mem_addr, mem_wdata);
            end
         end
      end

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
design/mips_pkg.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/memory_stage.sv
design/hazard_unit.sv
design/mips_core.sv
testbench/tb_memory.sv
testbench/tb_mips_core.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_mips_core
FILELIST   = all.f
FLAGS      = --timing --assert
LINT_FLAGS = --lint-only
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = all tests passed
FAIL_MSG   = tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
